//--- conv_layer_top.f
design/conv_pkg.sv
design/host_pkg.sv
design/window_buffer.sv
design/param_memory.sv
design/param_arbiter.sv
design/conv_unit.sv
design/conv_ctrl.sv
design/conv_layer_top.sv
testbench/conv_layer_asserts.sv
testbench/conv_layer_tb.sv

//--- design/conv_ctrl.sv
`timescale 1ns/1ns

module conv_ctrl (
	input  logic clk,
	input  logic rst_n,
	input  logic start,
	output logic ld_req,
	output logic [host_pkg::PARAM_ADDR_W-1:0] ld_addr,
	input  logic ld_gnt,
	input  logic rd_pending,
	output logic ld_valid,
	output logic [host_pkg::PARAM_ADDR_W-1:0] ld_idx,
	input  logic pix_valid,
	output logic pix_ready,
	output logic shift_en,
	output logic win_valid,
	input  logic res_valid,
	input  logic credit_return,
	output logic start_ok,
	output logic busy,
	output logic frame_done
);
	import conv_pkg::*;
	import host_pkg::*;

	ctrl_state_t state;
	logic [POS_W-1:0] row;
	logic [POS_W-1:0] col;
	logic [CRED_W-1:0] credits;
	logic [RES_W-1:0] res_cnt;
	logic at_window;
	logic take_credit;
	logic last_load;

	assign start_ok = (state == st_idle);
	assign busy = (state != st_idle);
	assign ld_valid = rd_pending; // read data is back this cycle

	// offered pixel closes a 3x3 window
	assign at_window = (row >= POS_W'(KSIZE-1)) && (col >= POS_W'(KSIZE-1));
	assign pix_ready = (state == st_stream) && !(at_window && credits == '0);
	assign shift_en = pix_valid && pix_ready;
	assign take_credit = shift_en && at_window;
	assign last_load = ld_addr == PARAM_ADDR_W'((NUM_UNITS-1)*UNIT_STRIDE + BIAS_OFFSET);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= st_idle;
			ld_req <= 1'b0;
			ld_addr <= '0;
			row <= '0;
			col <= '0;
			frame_done <= 1'b0;
		end else begin
			frame_done <= 1'b0;
			case (state)
				st_idle: begin
					if (start) begin
						state <= st_load;
						ld_req <= 1'b1;
						ld_addr <= '0;
						row <= '0;
						col <= '0;
					end
				end
				st_load: begin
					if (ld_gnt) begin
						if (last_load)
							ld_req <= 1'b0;
						else if (ld_addr[SLOT_W-1:0] == SLOT_W'(BIAS_OFFSET))
							ld_addr <= ld_addr + PARAM_ADDR_W'(UNIT_STRIDE - BIAS_OFFSET);
						else
							ld_addr <= ld_addr + 1'b1;
					end
					if (!ld_req && rd_pending)
						state <= st_stream; // last word lands this edge
				end
				st_stream: begin
					if (shift_en) begin
						if (col == POS_W'(IMG_SIZE-1)) begin
							col <= '0;
							row <= row + 1'b1;
							if (row == POS_W'(IMG_SIZE-1))
								state <= st_drain;
						end else begin
							col <= col + 1'b1;
						end
					end
				end
				st_drain: begin
					if (res_valid && res_cnt == RES_W'(OUT_SIZE*OUT_SIZE - 1)) begin
						state <= st_idle;
						frame_done <= 1'b1;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (ld_gnt)
			ld_idx <= ld_addr; // tag for the returning word
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			win_valid <= 1'b0;
			res_cnt <= '0;
		end else begin
			win_valid <= take_credit;
			if (start && state == st_idle)
				res_cnt <= '0;
			else if (res_valid)
				res_cnt <= res_cnt + 1'b1;
		end
	end

	// credit reserved at acceptance, never above the grant
	always_ff @(posedge clk) begin
		if (!rst_n)
			credits <= CRED_W'(OUT_CREDITS);
		else if (take_credit && !credit_return)
			credits <= credits - 1'b1;
		else if (!take_credit && credit_return && credits != CRED_W'(OUT_CREDITS))
			credits <= credits + 1'b1;
	end

endmodule

//--- design/conv_layer_top.sv
`timescale 1ns/1ns

module conv_layer_top (
	input  logic clk,
	input  logic rst_n,
	input  logic host_valid,
	input  host_pkg::host_op_t host_op,
	input  logic [host_pkg::PARAM_ADDR_W-1:0] host_addr,
	input  logic signed [conv_pkg::PIX_W-1:0] host_data,
	output logic host_ready,
	input  logic pix_valid,
	input  logic signed [conv_pkg::PIX_W-1:0] pix_data,
	output logic pix_ready,
	output logic out_valid,
	output logic signed [conv_pkg::ACC_W-1:0] out_data_0,
	output logic signed [conv_pkg::ACC_W-1:0] out_data_1,
	input  logic credit_return,
	output logic busy,
	output logic frame_done
);
	import conv_pkg::*;
	import host_pkg::*;

	logic start;
	logic start_ok;
	logic ld_req;
	logic ld_gnt;
	logic [PARAM_ADDR_W-1:0] ld_addr;
	logic rd_pending;
	logic ld_valid;
	logic [PARAM_ADDR_W-1:0] ld_idx;
	logic mem_we;
	logic mem_re;
	logic [PARAM_ADDR_W-1:0] mem_addr;
	logic signed [PIX_W-1:0] mem_wdata;
	logic signed [PIX_W-1:0] mem_rdata;
	logic shift_en;
	logic win_valid;
	logic signed [PIX_W-1:0] window [KTAPS];
	logic win_out_valid;
	logic res_valid_1;

	assign start = host_valid && host_ready && (host_op == op_start);

	conv_ctrl ctrl_i (
		.clk(clk), .rst_n(rst_n), .start(start),
		.ld_req(ld_req), .ld_addr(ld_addr), .ld_gnt(ld_gnt), .rd_pending(rd_pending),
		.ld_valid(ld_valid), .ld_idx(ld_idx),
		.pix_valid(pix_valid), .pix_ready(pix_ready), .shift_en(shift_en),
		.win_valid(win_valid), .res_valid(res_valid_1), .credit_return(credit_return),
		.start_ok(start_ok), .busy(busy), .frame_done(frame_done)
	);

	param_arbiter arb_i (
		.clk(clk), .rst_n(rst_n),
		.host_valid(host_valid), .host_op(host_op), .host_addr(host_addr),
		.host_data(host_data), .host_ready(host_ready), .start_ok(start_ok),
		.ld_req(ld_req), .ld_addr(ld_addr), .ld_gnt(ld_gnt),
		.mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
		.mem_re(mem_re), .rd_pending(rd_pending)
	);

	param_memory mem_i (
		.clk(clk), .we(mem_we), .re(mem_re), .addr(mem_addr),
		.wdata(mem_wdata), .rdata(mem_rdata)
	);

	window_buffer win_i (
		.clk(clk), .rst_n(rst_n), .shift_en(shift_en), .pix_data(pix_data),
		.win_valid(win_valid), .window(window), .win_out_valid(win_out_valid)
	);

	conv_unit unit_0 (
		.clk(clk), .rst_n(rst_n), .ld_valid(ld_valid), .ld_idx(ld_idx), .ld_data(mem_rdata),
		.window(window), .win_valid(win_out_valid),
		.res_valid(out_valid), .res_data(out_data_0)
	);

	// unit 1 sees its own block relabelled as block 0
	conv_unit unit_1 (
		.clk(clk), .rst_n(rst_n), .ld_valid(ld_valid),
		.ld_idx(ld_idx ^ PARAM_ADDR_W'(UNIT_STRIDE)), .ld_data(mem_rdata),
		.window(window), .win_valid(win_out_valid),
		.res_valid(res_valid_1), .res_data(out_data_1)
	);

endmodule

//--- design/conv_pkg.sv
package conv_pkg;

	// layer geometry
	localparam int IMG_SIZE = 6;
	localparam int KSIZE = 3;
	localparam int OUT_SIZE = IMG_SIZE - KSIZE + 1;
	localparam int NUM_UNITS = 2;

	localparam int PIX_W = 16; // pixels and weights, signed
	localparam int ACC_W = 32; // results wrap here

	localparam int OUT_CREDITS = 4;

	localparam int KTAPS = KSIZE * KSIZE;
	localparam int LINE_LEN = (KSIZE - 1) * IMG_SIZE + KSIZE; // two rows plus three taps

	// counter widths
	localparam int POS_W = $clog2(IMG_SIZE);
	localparam int CRED_W = $clog2(OUT_CREDITS + 1);
	localparam int RES_W = $clog2(OUT_SIZE * OUT_SIZE);

	typedef enum logic [1:0] {
		st_idle,
		st_load,
		st_stream,
		st_drain
	} ctrl_state_t;

endpackage

//--- design/conv_unit.sv
`timescale 1ns/1ns

module conv_unit (
	input  logic clk,
	input  logic rst_n,
	input  logic ld_valid,
	input  logic [host_pkg::PARAM_ADDR_W-1:0] ld_idx,
	input  logic signed [conv_pkg::PIX_W-1:0] ld_data,
	input  logic signed [conv_pkg::PIX_W-1:0] window [conv_pkg::KTAPS],
	input  logic win_valid,
	output logic res_valid,
	output logic signed [conv_pkg::ACC_W-1:0] res_data
);
	import conv_pkg::*;
	import host_pkg::*;

	logic signed [PIX_W-1:0] weights [KTAPS];
	logic signed [PIX_W-1:0] bias;
	logic signed [ACC_W-1:0] prod [KTAPS];
	logic signed [ACC_W-1:0] acc;
	logic prod_valid;
	logic own_block;
	logic [SLOT_W-1:0] slot;

	// block 0 of the index as seen on this port is ours
	assign own_block = ld_idx < UNIT_STRIDE;
	assign slot = ld_idx[SLOT_W-1:0];

	always_ff @(posedge clk) begin
		if (ld_valid && own_block) begin
			if (slot == SLOT_W'(BIAS_OFFSET))
				bias <= ld_data;
			else if (slot < SLOT_W'(KTAPS))
				weights[slot] <= ld_data;
		end
	end

	// stage one, products
	always_ff @(posedge clk) begin
		for (int k = 0; k < KTAPS; k++) begin
			prod[k] <= window[k] * weights[k];
		end
	end

	always_comb begin
		acc = ACC_W'(bias);
		for (int k = 0; k < KTAPS; k++) begin
			acc = acc + prod[k];
		end
	end

	// stage two, sum plus bias then relu
	always_ff @(posedge clk) begin
		res_data <= acc[ACC_W-1] ? '0 : acc;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			prod_valid <= 1'b0;
			res_valid <= 1'b0;
		end else begin
			prod_valid <= win_valid;
			res_valid <= prod_valid;
		end
	end

endmodule

//--- design/host_pkg.sv
package host_pkg;

	typedef enum logic [1:0] {
		op_nop,
		op_write_param,
		op_start
	} host_op_t;

	// parameter memory map
	localparam int PARAM_ADDR_W = 5;
	localparam int PARAM_WORDS = 32;
	localparam int UNIT_STRIDE = 16; // one block per unit
	localparam int BIAS_OFFSET = 9; // weights sit at 0..8, row-major

	// offset field of an address within a unit block
	localparam int SLOT_W = $clog2(UNIT_STRIDE);

endpackage

//--- design/param_arbiter.sv
`timescale 1ns/1ns

module param_arbiter (
	input  logic clk,
	input  logic rst_n,
	input  logic host_valid,
	input  host_pkg::host_op_t host_op,
	input  logic [host_pkg::PARAM_ADDR_W-1:0] host_addr,
	input  logic signed [conv_pkg::PIX_W-1:0] host_data,
	output logic host_ready,
	input  logic start_ok,
	input  logic ld_req,
	input  logic [host_pkg::PARAM_ADDR_W-1:0] ld_addr,
	output logic ld_gnt,
	output logic mem_we,
	output logic [host_pkg::PARAM_ADDR_W-1:0] mem_addr,
	output logic signed [conv_pkg::PIX_W-1:0] mem_wdata,
	output logic mem_re,
	output logic rd_pending
);
	import host_pkg::*;

	logic host_write;

	// start waits for an idle controller, everything else goes straight through
	assign host_ready = (host_op == op_start) ? start_ok : 1'b1;
	assign host_write = host_valid && (host_op == op_write_param);

	assign ld_gnt = ld_req && !host_write; // host first
	assign mem_we = host_write;
	assign mem_re = ld_gnt;
	assign mem_addr = host_write ? host_addr : ld_addr;
	assign mem_wdata = host_data;

	always_ff @(posedge clk) begin
		if (!rst_n)
			rd_pending <= 1'b0;
		else
			rd_pending <= ld_gnt;
	end

endmodule

//--- design/param_memory.sv
`timescale 1ns/1ns

module param_memory (
	input  logic clk,
	input  logic we,
	input  logic re,
	input  logic [host_pkg::PARAM_ADDR_W-1:0] addr,
	input  logic signed [conv_pkg::PIX_W-1:0] wdata,
	output logic signed [conv_pkg::PIX_W-1:0] rdata
);
	import conv_pkg::*;
	import host_pkg::*;

	logic signed [PIX_W-1:0] mem [PARAM_WORDS];

	always_ff @(posedge clk) begin
		if (we)
			mem[addr] <= wdata;
		if (re)
			rdata <= mem[addr]; // registered read
	end

endmodule

//--- design/window_buffer.sv
`timescale 1ns/1ns

module window_buffer (
	input  logic clk,
	input  logic rst_n,
	input  logic shift_en,
	input  logic signed [conv_pkg::PIX_W-1:0] pix_data,
	input  logic win_valid,
	output logic signed [conv_pkg::PIX_W-1:0] window [conv_pkg::KTAPS],
	output logic win_out_valid
);
	import conv_pkg::*;

	// taps[0] holds the newest pixel
	logic signed [PIX_W-1:0] taps [LINE_LEN];

	always_ff @(posedge clk) begin
		if (shift_en) begin
			taps[0] <= pix_data;
			for (int i = 1; i < LINE_LEN; i++) begin
				taps[i] <= taps[i-1];
			end
		end
	end

	// newest pixel is the bottom right corner of the window
	always_ff @(posedge clk) begin
		for (int r = 0; r < KSIZE; r++) begin
			for (int c = 0; c < KSIZE; c++) begin
				window[r*KSIZE + c] <= taps[(KSIZE-1-r)*IMG_SIZE + (KSIZE-1-c)];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			win_out_valid <= 1'b0;
		else
			win_out_valid <= win_valid; // flag rides with the window
	end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module conv_layer_tb -f conv_layer_top.f \
	--Mdir obj_dir -o conv_layer_sim

./obj_dir/conv_layer_sim | tee sim.log

if grep -qx "Done: no errors" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

//--- testbench/conv_layer_asserts.sv
`timescale 1ns/1ns

module conv_layer_asserts (
	input logic clk,
	input logic rst_n,
	input logic out_valid,
	input logic win_valid,
	input logic credit_return,
	input logic host_valid,
	input logic host_ready,
	input host_pkg::host_op_t host_op,
	input logic ld_req,
	input logic [host_pkg::PARAM_ADDR_W-1:0] ld_addr
);
	import conv_pkg::*;
	import host_pkg::*;

	logic [CRED_W-1:0] reserved; // credits taken and not yet returned
	logic host_write;

	assign host_write = host_valid && host_ready && (host_op == op_write_param);

	always_ff @(posedge clk) begin
		if (!rst_n)
			reserved <= '0;
		else if (win_valid && !credit_return)
			reserved <= reserved + 1'b1;
		else if (!win_valid && credit_return && reserved != '0)
			reserved <= reserved - 1'b1;
	end

	a_out_has_credit: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> reserved != '0)
		else $error("out_valid with no credit reserved");

	// loader request that meets a host write keeps its address
	a_one_grant: assert property (@(posedge clk) disable iff (!rst_n)
		host_write && ld_req |=> ld_req && $stable(ld_addr))
		else $error("host and loader granted in the same cycle");

	a_quiet_reset: assert property (@(posedge clk) !rst_n |=> !out_valid)
		else $error("out_valid high during reset");

endmodule

bind conv_layer_top conv_layer_asserts asserts_i (
	.clk(clk),
	.rst_n(rst_n),
	.out_valid(out_valid),
	.win_valid(win_valid),
	.credit_return(credit_return),
	.host_valid(host_valid),
	.host_ready(host_ready),
	.host_op(host_op),
	.ld_req(ld_req),
	.ld_addr(ld_addr)
);

//--- testbench/conv_layer_tb.sv
`timescale 1ns/1ns

module conv_layer_tb;
	import conv_pkg::*;
	import host_pkg::*;

	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 16;
	localparam int LAT_EDGES = 3; // window register, products, sum
	localparam int FRAME_CYCLES = 160; // params, load, stream, stall and drain
	localparam int WATCHDOG_CYCLES = 2 * (RESET_CYCLES + 5 * FRAME_CYCLES);
	localparam int NPIX = IMG_SIZE * IMG_SIZE;

	logic clk;
	logic rst_n;
	logic host_valid;
	host_op_t host_op;
	logic [PARAM_ADDR_W-1:0] host_addr;
	logic signed [PIX_W-1:0] host_data;
	logic host_ready;
	logic pix_valid;
	logic signed [PIX_W-1:0] pix_data;
	logic pix_ready;
	logic out_valid;
	logic signed [ACC_W-1:0] out_data_0;
	logic signed [ACC_W-1:0] out_data_1;
	logic credit_return;
	logic busy;
	logic frame_done;

	logic [31:0] lcg_state = 32'h7b3944b2;
	logic signed [PIX_W-1:0] wt [NUM_UNITS][KTAPS];
	logic signed [PIX_W-1:0] bias_v [NUM_UNITS];
	logic signed [PIX_W-1:0] img [NPIX];
	logic signed [ACC_W-1:0] exp0_q [$];
	logic signed [ACC_W-1:0] exp1_q [$];
	int accept_q [$]; // edge index of each window-completing pixel
	int cyc = 0;
	int errors = 0;
	int out_cnt = 0;
	int done_cnt = 0;
	int done_base = 0;
	int owed = 0;
	int t_start = 0;
	int t_first = 0;
	bit hold_credits;

	conv_layer_top dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD/2) clk = ~clk;
	end

	always @(posedge clk) cyc <= cyc + 1;

	function logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function logic signed [PIX_W-1:0] small_val(); // -16 to 15
		logic [31:0] v;
		v = lcg_next();
		return PIX_W'(int'(v[20:16]) - 16);
	endfunction

	task automatic check_result(input string what, input logic signed [ACC_W-1:0] got,
			input logic signed [ACC_W-1:0] exp);
		if (got !== exp) begin
			errors++;
			$display("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_flag(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			errors++;
			$display("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	// sum of products plus bias, then relu, raster order
	task build_expected();
		logic signed [ACC_W-1:0] acc;
		exp0_q.delete();
		exp1_q.delete();
		accept_q.delete();
		for (int r = 0; r < OUT_SIZE; r++) begin
			for (int c = 0; c < OUT_SIZE; c++) begin
				for (int u = 0; u < NUM_UNITS; u++) begin
					acc = ACC_W'(bias_v[u]);
					for (int k = 0; k < KTAPS; k++)
						acc += ACC_W'(img[(r + k/KSIZE)*IMG_SIZE + c + k%KSIZE]) * ACC_W'(wt[u][k]);
					if (acc < 0)
						acc = '0;
					if (u == 0)
						exp0_q.push_back(acc);
					else
						exp1_q.push_back(acc);
				end
			end
		end
	endtask

	task host_cmd(input host_op_t op, input int addr, input logic signed [PIX_W-1:0] data);
		host_valid = 1'b1;
		host_op = op;
		host_addr = PARAM_ADDR_W'(addr);
		host_data = data;
		do @(posedge clk); while (!host_ready);
		#1;
		host_valid = 1'b0;
		host_op = op_nop;
	endtask

	task load_params();
		for (int u = 0; u < NUM_UNITS; u++) begin
			for (int k = 0; k < KTAPS; k++)
				host_cmd(op_write_param, u*UNIT_STRIDE + k, wt[u][k]);
			host_cmd(op_write_param, u*UNIT_STRIDE + BIAS_OFFSET, bias_v[u]);
		end
	endtask

	task random_image();
		for (int i = 0; i < NPIX; i++)
			img[i] = small_val();
	endtask

	task start_frame();
		build_expected();
		out_cnt = 0;
		done_base = done_cnt;
		host_cmd(op_start, 0, '0);
		t_start = cyc;
		host_op = op_start; // offered without valid while the frame runs
		@(posedge clk);
		check_flag("host_ready for start while busy", host_ready, 1'b0);
		check_flag("busy during frame", busy, 1'b1);
		#1;
		host_op = op_nop;
	endtask

	task stream_pixels();
		for (int i = 0; i < NPIX; i++) begin
			pix_valid = 1'b1;
			pix_data = img[i];
			do @(posedge clk); while (!pix_ready);
			#1;
			if (i == 0)
				t_first = cyc;
			if (i / IMG_SIZE >= KSIZE-1 && i % IMG_SIZE >= KSIZE-1)
				accept_q.push_back(cyc);
		end
		pix_valid = 1'b0;
	endtask

	task finish_frame();
		wait (done_cnt != done_base);
		repeat (4) @(posedge clk);
		#1;
		check_flag("single frame_done pulse", done_cnt == done_base + 1, 1'b1);
		check_flag("all results seen", out_cnt == OUT_SIZE*OUT_SIZE, 1'b1);
	endtask

	// consumer side, compares each result pair as it leaves
	always @(posedge clk) begin
		if (rst_n && frame_done)
			done_cnt++;
		if (rst_n && out_valid) begin
			out_cnt++;
			owed++;
			if (exp0_q.size() == 0) begin
				errors++;
				$display("a result came out at %0t ns with none expected", $time);
			end else begin
				check_result("unit 0 result", out_data_0, exp0_q.pop_front());
				check_result("unit 1 result", out_data_1, exp1_q.pop_front());
				check_flag("output latency", cyc - accept_q.pop_front() == LAT_EDGES, 1'b1);
			end
		end
	end

	always @(posedge clk) begin
		#1;
		if (owed > 0 && !hold_credits) begin
			credit_return = 1'b1;
			owed--;
		end else begin
			credit_return = 1'b0;
		end
	end

	task test_reset();
		@(posedge clk);
		check_flag("pix_ready after reset", pix_ready, 1'b0);
		check_flag("out_valid after reset", out_valid, 1'b0);
		check_flag("busy after reset", busy, 1'b0);
		check_flag("frame_done after reset", frame_done, 1'b0);
		#1;
	endtask

	task test_basic_frame();
		for (int u = 0; u < NUM_UNITS; u++) begin
			for (int k = 0; k < KTAPS; k++)
				wt[u][k] = small_val();
			bias_v[u] = small_val();
		end
		random_image();
		load_params();
		start_frame();
		stream_pixels();
		finish_frame();
		check_flag("load time", t_first - t_start >= 21, 1'b1);
	endtask

	task test_relu_bias();
		// non-negative pixels, unit 0 always below zero, unit 1 always above
		for (int k = 0; k < KTAPS; k++) begin
			wt[0][k] = PIX_W'(-(small_val() + 17));
			wt[1][k] = PIX_W'(small_val() + 17);
		end
		bias_v[0] = -16'sd3;
		bias_v[1] = 16'sd5;
		for (int i = 0; i < NPIX; i++)
			img[i] = PIX_W'(small_val() + 16);
		load_params();
		start_frame();
		stream_pixels();
		finish_frame();
	endtask

	task test_backpressure();
		random_image();
		hold_credits = 1'b1;
		start_frame();
		fork
			stream_pixels();
			begin
				wait (out_cnt == OUT_CREDITS);
				repeat (8) @(posedge clk);
				#1;
				check_flag("pix_ready with no credit", pix_ready, 1'b0);
				check_flag("results capped by credits", out_cnt == OUT_CREDITS, 1'b1);
				@(posedge clk);
				hold_credits = 1'b0;
			end
		join
		finish_frame();
	endtask

	task test_host_priority();
		random_image();
		start_frame();
		fork
			stream_pixels();
			load_params(); // same values again while the loader runs
		join
		finish_frame();
		check_flag("loader waited for host", t_first - t_start >= 21 + NUM_UNITS*(KTAPS+1), 1'b1);
	endtask

	task test_latency();
		random_image();
		start_frame();
		stream_pixels();
		finish_frame();
		check_flag("every window timed", accept_q.size() == 0, 1'b1);
	endtask

	initial begin
		rst_n = 1'b0;
		host_valid = 1'b0;
		host_op = op_nop;
		host_addr = '0;
		host_data = '0;
		pix_valid = 1'b0;
		pix_data = '0;
		credit_return = 1'b0;
		hold_credits = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst_n = 1'b1;
		test_reset();
		test_basic_frame();
		test_relu_bias();
		test_backpressure();
		test_host_priority();
		test_latency();
		$display("errors: %0d", errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired before the tests finished");
		$display("Done: errors found");
		$finish;
	end

endmodule
